// File: rtl/cache_pkg.sv
/* Shared widths, size and protection types, cache geometry functions,
   core and memory request structs, compare stage states */
`default_nettype none

package cache_pkg;

  //////////////////////////////////////////////////
  // Widths and field types
  //////////////////////////////////////////////////

  // Default address and data width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [XLEN/8-1:0] byte_en_t;

  // Access size, encoded as on the core bus
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } biu_size_t;

  // Privileged, instruction, cacheable hint
  typedef logic [2:0] biu_prot_t;

  //////////////////////////////////////////////////
  // Geometry, SIZE in bytes and block size in bits
  //////////////////////////////////////////////////

  function automatic int no_of_sets(input int size, input int block_size, input int ways);
    return (size * 8) / (block_size * ways);
  endfunction

  function automatic int no_of_block_offset_bits(input int block_size);
    return $clog2(block_size / 8);
  endfunction

  function automatic int no_of_index_bits(input int sets);
    return $clog2(sets);
  endfunction

  function automatic int no_of_tag_bits(input int xlen, input int idx_bits, input int offs_bits);
    return xlen - idx_bits - offs_bits;
  endfunction

  // Way number width, one bit minimum for a direct mapped cache
  function automatic int no_of_way_bits(input int ways);
    return (ways > 1) ? $clog2(ways) : 1;
  endfunction

  //////////////////////////////////////////////////
  // Request structs and states
  //////////////////////////////////////////////////

  // One core request as seen by the setup stage
  typedef struct packed {
    xlen_t     adr;
    biu_size_t size;
    logic      lock;
    biu_prot_t prot;
    logic      we;
    xlen_t     wdata;
    logic      cacheable;
    logic      misaligned;
  } cpu_req_t;

  // One access on the memory port
  typedef struct packed {
    xlen_t     adr;
    logic      we;
    byte_en_t  be;
    xlen_t     wdata;
    logic      lock;
    biu_prot_t prot;
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE,
    MEM_READ,
    MEM_WRITE
  } cmp_state_e;

endpackage

`default_nettype wire

// File: rtl/cache_setup.sv
/* Cache setup stage, registers the core request and drives the array index */
`timescale 1ns/1ps
`default_nettype none

module cache_setup
  import cache_pkg::*;
#(
  parameter  int XLEN          = cache_pkg::XLEN,
  parameter  int SIZE          = 64,
  parameter  int WAYS          = 2,

  localparam int SETS          = no_of_sets(SIZE, XLEN, WAYS),
  localparam int BLK_OFFS_BITS = no_of_block_offset_bits(XLEN),
  localparam int IDX_BITS      = no_of_index_bits(SETS)
)
(
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                stall_i,
  input  logic                flush_i,
  input  logic                req_i,
  input  cpu_req_t            req_data_i,

  output logic                stage_valid_o,
  output cpu_req_t            stage_req_o,
  output logic [IDX_BITS-1:0] idx_o
);

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////

  logic                flush_dly;
  logic [IDX_BITS-1:0] adr_idx;
  logic [IDX_BITS-1:0] adr_idx_dly;

  // Flush seen one cycle late by the index mux
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni) flush_dly <= 1'b0;
    else         flush_dly <= flush_i;

  // Request valid, killed by flush, held during a stall
  always_ff @(posedge clk_i or negedge rst_ni)
    if      (!rst_ni)  stage_valid_o <= 1'b0;
    else if (flush_i)  stage_valid_o <= 1'b0;
    else if (!stall_i) stage_valid_o <= req_i;

  // Request fields
  always_ff @(posedge clk_i)
    if (!stall_i) stage_req_o <= req_data_i;

  //////////////////////////////////////////////////
  // Array index
  //////////////////////////////////////////////////

  // Set index straight from the live address
  assign adr_idx = req_data_i.adr[BLK_OFFS_BITS +: IDX_BITS];

  // Held copy, so the arrays keep reading the staged set
  // Also reloaded right after a flush
  always_ff @(posedge clk_i)
    if (!stall_i || flush_dly) adr_idx_dly <= adr_idx;

  // Memories register this index themselves
  assign idx_o = (stall_i && !flush_dly) ? adr_idx_dly : adr_idx;

  // Staged request frozen while the compare stage stalls
  a_stage_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    stall_i && stage_valid_o |=> $stable(stage_req_o) && stage_valid_o
  );

endmodule

`default_nettype wire

// File: rtl/cache_ways.sv
/* Tag, valid and data arrays of all ways, registered read, byte-enabled
   write port, flush clear and per-set round-robin victim pointer */
`timescale 1ns/1ps
`default_nettype none

module cache_ways
  import cache_pkg::*;
#(
  parameter  int XLEN          = cache_pkg::XLEN,
  parameter  int SIZE          = 64,
  parameter  int WAYS          = 2,

  localparam int SETS          = no_of_sets(SIZE, XLEN, WAYS),
  localparam int BLK_OFFS_BITS = no_of_block_offset_bits(XLEN),
  localparam int IDX_BITS      = no_of_index_bits(SETS),
  localparam int TAG_BITS      = no_of_tag_bits(XLEN, IDX_BITS, BLK_OFFS_BITS),
  localparam int WAY_BITS      = no_of_way_bits(WAYS)
)
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,

  // Read side
  input  logic [IDX_BITS     -1:0] rd_idx_i,
  output logic [WAYS*TAG_BITS-1:0] tags_o,
  output logic [WAYS         -1:0] valids_o,
  output logic [WAYS*XLEN    -1:0] datas_o,
  output logic [WAY_BITS     -1:0] victim_o,

  // Write side
  input  logic                     wr_en_i,
  input  logic [WAY_BITS     -1:0] wr_way_i,
  input  logic [IDX_BITS     -1:0] wr_idx_i,
  input  logic [TAG_BITS     -1:0] wr_tag_i,
  input  logic [XLEN         -1:0] wr_data_i,
  input  logic [XLEN/8       -1:0] wr_be_i,
  input  logic                     alloc_i
);

  logic [WAYS-1:0][SETS-1:0]     valid_q;
  logic [SETS-1:0][WAY_BITS-1:0] victim_q;
  logic [IDX_BITS-1:0]           idx_q;

  //////////////////////////////////////////////////
  // Tag and data memories, one pair per way
  //////////////////////////////////////////////////

  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way
    logic [TAG_BITS-1:0] tag_mem [SETS];
    logic [XLEN    -1:0] data_mem [SETS];
    logic [TAG_BITS-1:0] tag_q;
    logic [XLEN    -1:0] data_q;
    logic                way_we;

    assign way_we = wr_en_i && (wr_way_i == WAY_BITS'(w));

    // Write port, data under byte enables
    always_ff @(posedge clk_i)
      if (way_we)
      begin
        tag_mem[wr_idx_i] <= wr_tag_i;
        for (int b = 0; b < XLEN/8; b++)
          if (wr_be_i[b]) data_mem[wr_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];
      end

    // Registered read, returns old contents on a same-edge write
    always_ff @(posedge clk_i)
    begin
      tag_q  <= tag_mem[rd_idx_i];
      data_q <= data_mem[rd_idx_i];
    end

    assign tags_o[w*TAG_BITS +: TAG_BITS] = tag_q;
    assign datas_o[w*XLEN +: XLEN]        = data_q;
    assign valids_o[w]                    = valid_q[w][idx_q];
  end

  //////////////////////////////////////////////////
  // Valid bits and victim pointers in flops
  //////////////////////////////////////////////////

  // Read index copy, lines valid and victim up with the memories
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni) idx_q <= '0;
    else         idx_q <= rd_idx_i;

  // Flush wipes every line at once
  always_ff @(posedge clk_i or negedge rst_ni)
    if      (!rst_ni)            valid_q <= '0;
    else if (flush_i)            valid_q <= '0;
    else if (wr_en_i && alloc_i) valid_q[wr_way_i][wr_idx_i] <= 1'b1;

  // Round-robin, next way after every refill of the set
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni) victim_q <= '0;
    else if (wr_en_i && alloc_i)
    begin
      if (victim_q[wr_idx_i] == WAY_BITS'(WAYS-1)) victim_q[wr_idx_i] <= '0;
      else victim_q[wr_idx_i] <= victim_q[wr_idx_i] + 1'b1;
    end

  assign victim_o = victim_q[idx_q];

  // Compare stage never points past the last way
  a_way_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wr_en_i |-> (int'(wr_way_i) < WAYS)
  );

endmodule

`default_nettype wire

// File: rtl/cache_compare.sv
/* Compare stage, tag compare and hit select, byte enables and merge,
   memory access FSM for misses and write-through, core response */
`timescale 1ns/1ps
`default_nettype none

module cache_compare
  import cache_pkg::*;
#(
  parameter  int XLEN          = cache_pkg::XLEN,
  parameter  int SIZE          = 64,
  parameter  int WAYS          = 2,

  localparam int SETS          = no_of_sets(SIZE, XLEN, WAYS),
  localparam int BLK_OFFS_BITS = no_of_block_offset_bits(XLEN),
  localparam int IDX_BITS      = no_of_index_bits(SETS),
  localparam int TAG_BITS      = no_of_tag_bits(XLEN, IDX_BITS, BLK_OFFS_BITS),
  localparam int WAY_BITS      = no_of_way_bits(WAYS),
  localparam int BE_W          = XLEN/8
)
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic                     stage_valid_i,
  input  cpu_req_t                 stage_req_i,

  // Array read data, aligned with the staged request
  input  logic [WAYS*TAG_BITS-1:0] tags_i,
  input  logic [WAYS         -1:0] valids_i,
  input  logic [WAYS*XLEN    -1:0] datas_i,
  input  logic [WAY_BITS     -1:0] victim_i,

  // Array write port
  output logic                     wr_en_o,
  output logic [WAY_BITS     -1:0] wr_way_o,
  output logic [IDX_BITS     -1:0] wr_idx_o,
  output logic [TAG_BITS     -1:0] wr_tag_o,
  output logic [XLEN         -1:0] wr_data_o,
  output logic [BE_W         -1:0] wr_be_o,
  output logic                     alloc_o,

  // Core response
  output logic                     stall_o,
  output logic                     ack_o,
  output logic                     err_o,
  output logic [XLEN         -1:0] rdata_o,

  // Memory port
  output logic                     mem_valid_o,
  output mem_req_t                 mem_req_o,
  input  logic                     mem_ack_i,
  input  logic [XLEN         -1:0] mem_rdata_i
);

  cmp_state_e          state_q;
  cmp_state_e          state_d;
  logic                done_q;
  logic [XLEN    -1:0] rdata_q;
  logic                active;
  logic                need_mem;
  logic [TAG_BITS-1:0] core_tag;
  logic [IDX_BITS-1:0] core_idx;
  logic [WAYS    -1:0] hit_way;
  logic                hit;
  logic [WAY_BITS-1:0] hit_idx;
  logic [XLEN    -1:0] hit_data;
  logic [BE_W    -1:0] be_mask;
  logic [BE_W    -1:0] byte_en;
  logic [XLEN    -1:0] wdata_al;

  //////////////////////////////////////////////////
  // Tag compare
  //////////////////////////////////////////////////

  assign core_tag = stage_req_i.adr[XLEN-1 -: TAG_BITS];
  assign core_idx = stage_req_i.adr[BLK_OFFS_BITS +: IDX_BITS];

  always_comb
  begin
    hit_idx  = '0;
    hit_data = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      hit_way[w] = valids_i[w] && (tags_i[w*TAG_BITS +: TAG_BITS] == core_tag);
      if (hit_way[w])
      begin
        hit_idx  = WAY_BITS'(w);
        hit_data = datas_i[w*XLEN +: XLEN];
      end
    end
  end

  assign hit = |hit_way;

  // Byte lanes from size, data copied into every lane
  always_comb
  begin
    case (stage_req_i.size)
      BYTE:
      begin
        be_mask  = BE_W'(1);
        wdata_al = {(XLEN/8){stage_req_i.wdata[7:0]}};
      end
      HWORD:
      begin
        be_mask  = BE_W'(3);
        wdata_al = {(XLEN/16){stage_req_i.wdata[15:0]}};
      end
      WORD:
      begin
        be_mask  = BE_W'(15);
        wdata_al = {(XLEN/32){stage_req_i.wdata[31:0]}};
      end
      default:
      begin
        be_mask  = '1;
        wdata_al = stage_req_i.wdata;
      end
    endcase
    byte_en = be_mask << stage_req_i.adr[BLK_OFFS_BITS-1:0];
  end

  //////////////////////////////////////////////////
  // Memory access FSM
  //////////////////////////////////////////////////

  // Staged request not yet answered
  assign active   = stage_valid_i && !done_q;
  // Everything but a cacheable read hit goes to memory
  assign need_mem = !stage_req_i.misaligned &&
                    (stage_req_i.we || !stage_req_i.cacheable || !hit);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (active && need_mem) state_d = stage_req_i.we ? MEM_WRITE : MEM_READ;
      MEM_READ,
      MEM_WRITE:
        if (mem_ack_i) state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // One cycle marker, keeps the old request from restarting
      done_q  <= (state_q != IDLE) && mem_ack_i;
    end

  always_ff @(posedge clk_i)
    if (state_q == MEM_READ && mem_ack_i) rdata_q <= mem_rdata_i;

  // Request fields are held by the setup stage during the access
  assign mem_valid_o       = (state_q != IDLE);
  assign mem_req_o.adr     = {stage_req_i.adr[XLEN-1:BLK_OFFS_BITS], {BLK_OFFS_BITS{1'b0}}};
  assign mem_req_o.we      = (state_q == MEM_WRITE);
  assign mem_req_o.be      = (state_q == MEM_WRITE) ? byte_en : '1;
  assign mem_req_o.wdata   = wdata_al;
  assign mem_req_o.lock    = stage_req_i.lock;
  assign mem_req_o.prot    = stage_req_i.prot;

  //////////////////////////////////////////////////
  // Array updates and core response
  //////////////////////////////////////////////////

  // Refill into victim, or merge a write hit, on the memory acknowledge
  assign alloc_o   = (state_q == MEM_READ);
  assign wr_en_o   = mem_ack_i && stage_req_i.cacheable &&
                     (alloc_o || (state_q == MEM_WRITE && hit));
  assign wr_way_o  = alloc_o ? victim_i : hit_idx;
  assign wr_idx_o  = core_idx;
  assign wr_tag_o  = core_tag;
  assign wr_data_o = alloc_o ? mem_rdata_i : wdata_al;
  assign wr_be_o   = alloc_o ? '1 : byte_en;

  assign stall_o = (state_q != IDLE) || (active && need_mem);
  assign ack_o   = done_q ||
                   (active && state_q == IDLE && !need_mem && !stage_req_i.misaligned);
  assign err_o   = active && stage_req_i.misaligned;
  assign rdata_o = done_q ? rdata_q : hit_data;

  a_mem_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_valid_o && !mem_ack_i |=> $stable(mem_req_o)
  );

  // Same line never sits in two ways
  a_one_hit : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    stage_valid_i |-> $onehot0(hit_way)
  );

endmodule

`default_nettype wire

// File: rtl/cache_top.sv
/* Level-1 data cache top, setup, ways and compare stages wired to core and memory */
`timescale 1ns/1ps
`default_nettype none

module cache_top
  import cache_pkg::*;
#(
  parameter  int XLEN          = cache_pkg::XLEN,
  parameter  int SIZE          = 64,
  parameter  int WAYS          = 2,

  localparam int SETS          = no_of_sets(SIZE, XLEN, WAYS),
  localparam int BLK_OFFS_BITS = no_of_block_offset_bits(XLEN),
  localparam int IDX_BITS      = no_of_index_bits(SETS),
  localparam int TAG_BITS      = no_of_tag_bits(XLEN, IDX_BITS, BLK_OFFS_BITS),
  localparam int WAY_BITS      = no_of_way_bits(WAYS)
)
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,

  // Core side
  input  logic            req_i,
  input  cpu_req_t        req_data_i,
  output logic            stall_o,
  output logic            ack_o,
  output logic            err_o,
  output logic [XLEN-1:0] rdata_o,

  // Memory side
  output logic            mem_valid_o,
  output mem_req_t        mem_req_o,
  input  logic            mem_ack_i,
  input  logic [XLEN-1:0] mem_rdata_i
);

  //////////////////////////////////////////////////
  // Stage interconnect
  //////////////////////////////////////////////////

  logic                     stage_valid;
  cpu_req_t                 stage_req;
  logic [IDX_BITS     -1:0] idx;
  logic [WAYS*TAG_BITS-1:0] tags;
  logic [WAYS         -1:0] valids;
  logic [WAYS*XLEN    -1:0] datas;
  logic [WAY_BITS     -1:0] victim;
  logic                     wr_en;
  logic [WAY_BITS     -1:0] wr_way;
  logic [IDX_BITS     -1:0] wr_idx;
  logic [TAG_BITS     -1:0] wr_tag;
  logic [XLEN         -1:0] wr_data;
  logic [XLEN/8       -1:0] wr_be;
  logic                     alloc;

  // Request register and index, back-pressured by the compare stage
  cache_setup #(.XLEN(XLEN), .SIZE(SIZE), .WAYS(WAYS)) u_setup (
    .clk_i, .rst_ni, .stall_i(stall_o), .flush_i, .req_i, .req_data_i,
    .stage_valid_o(stage_valid), .stage_req_o(stage_req), .idx_o(idx)
  );

  cache_ways #(.XLEN(XLEN), .SIZE(SIZE), .WAYS(WAYS)) u_ways (
    .clk_i, .rst_ni, .flush_i, .rd_idx_i(idx),
    .tags_o(tags), .valids_o(valids), .datas_o(datas), .victim_o(victim),
    .wr_en_i(wr_en), .wr_way_i(wr_way), .wr_idx_i(wr_idx), .wr_tag_i(wr_tag),
    .wr_data_i(wr_data), .wr_be_i(wr_be), .alloc_i(alloc)
  );

  // Hit check, memory FSM and core answer
  cache_compare #(.XLEN(XLEN), .SIZE(SIZE), .WAYS(WAYS)) u_compare (
    .clk_i, .rst_ni, .stage_valid_i(stage_valid), .stage_req_i(stage_req),
    .tags_i(tags), .valids_i(valids), .datas_i(datas), .victim_i(victim),
    .wr_en_o(wr_en), .wr_way_o(wr_way), .wr_idx_o(wr_idx), .wr_tag_o(wr_tag),
    .wr_data_o(wr_data), .wr_be_o(wr_be), .alloc_o(alloc),
    .stall_o, .ack_o, .err_o, .rdata_o,
    .mem_valid_o, .mem_req_o, .mem_ack_i, .mem_rdata_i
  );

endmodule

`default_nettype wire

// File: sim/tb_cache.sv
/* Directed testbench for the data cache, clock and reset, memory model with
   LFSR delays, check task and one task per tested behavior */
`timescale 1ns/1ps
`default_nettype none

module tb_cache
  import cache_pkg::*;
();

  localparam int SIZE    = 64;
  localparam int WAYS    = 2;
  localparam int TIMEOUT = 100;

  logic     clk_i;
  logic     rst_ni;
  logic     flush_i;
  logic     req_i;
  cpu_req_t req_data_i;
  logic     stall_o;
  logic     ack_o;
  logic     err_o;
  xlen_t    rdata_o;
  logic     mem_valid_o;
  mem_req_t mem_req_o;
  logic     mem_ack_i;
  xlen_t    mem_rdata_i;

  // Memory model state
  xlen_t       mem [xlen_t];
  int          rd_cnt;
  int          wr_cnt;
  mem_req_t    last_req;
  logic [31:0] lfsr_q;

  // Results of the last access
  xlen_t got_data;
  logic  got_err;
  logic  got_stall;
  int    got_ops;
  int    got_cycles;

  cache_top #(.XLEN(32), .SIZE(SIZE), .WAYS(WAYS)) dut (
    .clk_i, .rst_ni, .flush_i, .req_i, .req_data_i,
    .stall_o, .ack_o, .err_o, .rdata_o,
    .mem_valid_o, .mem_req_o, .mem_ack_i, .mem_rdata_i
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Unwritten words read as their address with a fixed pattern
  function automatic xlen_t mem_word(input xlen_t adr);
    if (mem.exists(adr)) return mem[adr];
    return adr ^ 32'h5a5a_0000;
  endfunction

  // Lanes touched by one store of the given size at a byte offset
  function automatic byte_en_t lanes(input biu_size_t size, input int off);
    int n;
    n = (size == BYTE) ? 1 : (size == HWORD) ? 2 : 4;
    return byte_en_t'(((1 << n) - 1) << off);
  endfunction

  // Low bytes of data land in the addressed lanes, the rest stays
  function automatic xlen_t merge(input xlen_t old, input xlen_t data,
                                  input biu_size_t size, input int off);
    xlen_t    res;
    byte_en_t be;
    res = old;
    be  = lanes(size, off);
    for (int i = 0; i < 4; i++)
      if (be[i]) res[8*i +: 8] = data[8*(i-off) +: 8];
    return res;
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp)
      fail_stop($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                          $time, name, got, exp));
  endtask

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  // Acknowledges each access after 1 to 4 cycles
  initial
  begin
    int    delay;
    xlen_t word;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    rd_cnt      = 0;
    wr_cnt      = 0;
    lfsr_q      = 32'hc9fc_fe12;
    forever
    begin
      @(negedge clk_i);
      mem_ack_i = 1'b0;
      if (mem_valid_o)
      begin
        // Two LFSR bits give the extra wait
        delay = 0;
        for (int i = 0; i < 2; i++)
        begin
          lfsr_q = lfsr_next(lfsr_q);
          delay  = (delay << 1) | int'(lfsr_q[0]);
        end
        repeat (delay) @(negedge clk_i);
        last_req = mem_req_o;
        word     = mem_word(mem_req_o.adr);
        if (mem_req_o.we)
        begin
          for (int b = 0; b < 4; b++)
            if (mem_req_o.be[b]) word[8*b +: 8] = mem_req_o.wdata[8*b +: 8];
          mem[mem_req_o.adr] = word;
          wr_cnt++;
        end
        else
          rd_cnt++;
        mem_rdata_i = word;
        mem_ack_i   = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Core side access
  //////////////////////////////////////////////////

  // One request, waits for ack_o or err_o
  task automatic access(input xlen_t adr, input biu_size_t size, input logic we,
                        input xlen_t wdata, input logic cacheable,
                        input logic misaligned);
    int ops0;
    int n;
    n = 0;
    @(negedge clk_i);
    while (stall_o)
    begin
      n++;
      if (n > TIMEOUT) fail_stop("Timeout: stall_o stayed high before a new request");
      @(negedge clk_i);
    end
    ops0                  = rd_cnt + wr_cnt;
    req_i                 = 1'b1;
    req_data_i.adr        = adr;
    req_data_i.size       = size;
    // Lock and protection vary per request and pass through to memory
    req_data_i.lock       = we;
    req_data_i.prot       = adr[4:2];
    req_data_i.we         = we;
    req_data_i.wdata      = wdata;
    req_data_i.cacheable  = cacheable;
    req_data_i.misaligned = misaligned;
    // Taken at the rising edge in between
    @(negedge clk_i);
    req_i      = 1'b0;
    got_cycles = 1;
    got_stall  = stall_o;
    while (!ack_o && !err_o)
    begin
      if (got_cycles >= TIMEOUT) fail_stop("Timeout: no ack_o or err_o for a request");
      @(negedge clk_i);
      got_cycles++;
      got_stall = got_stall | stall_o;
    end
    got_data = rdata_o;
    got_err  = err_o;
    got_ops  = rd_cnt + wr_cnt - ops0;
  endtask

  // Word read, data taken from the memory model
  task automatic read_expect(input xlen_t adr, input logic cacheable, input int ops,
                             input string what);
    xlen_t exp;
    exp = mem_word(adr);
    access(adr, WORD, 1'b0, '0, cacheable, 1'b0);
    check({what, " rdata_o"}, got_data, exp);
    check({what, " memory accesses"}, got_ops, ops);
    check({what, " err_o"}, got_err, 1'b0);
    // Hits answer in the cycle after acceptance, memory reads stall
    if (ops == 0)
      check({what, " ack_o latency"}, got_cycles, 1);
    else
      check({what, " stall_o"}, got_stall, 1'b1);
  endtask

  // Store, then memory word and byte enables against the merge rule
  task automatic write_check(input xlen_t adr, input biu_size_t size, input xlen_t data,
                             inout xlen_t exp);
    xlen_t base;
    int    off;
    base = {adr[31:2], 2'b00};
    off  = int'(adr[1:0]);
    exp  = merge(exp, data, size, off);
    access(adr, size, 1'b1, data, 1'b1, 1'b0);
    check("write memory accesses", got_ops, 1);
    check("mem_req_o.adr", last_req.adr, base);
    check("mem_req_o.be", xlen_t'(last_req.be), xlen_t'(lanes(size, off)));
    check("mem_req_o.lock", last_req.lock, 1'b1);
    check("mem_req_o.prot", last_req.prot, adr[4:2]);
    check("memory word after write", mem_word(base), exp);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_miss_then_hit();
    xlen_t a;
    a = 32'h0000_0104;
    access(a, WORD, 1'b0, '0, 1'b1, 1'b0);
    check("miss rdata_o", got_data, a ^ 32'h5a5a_0000);
    check("miss memory accesses", got_ops, 1);
    check("miss mem_req_o.adr", last_req.adr, a);
    check("miss mem_req_o.lock", last_req.lock, 1'b0);
    check("miss mem_req_o.prot", last_req.prot, a[4:2]);
    read_expect(a, 1'b1, 0, "hit");
    check("hit stall_o", got_stall, 1'b0);
  endtask

  task automatic test_write_merge();
    xlen_t a;
    xlen_t exp;
    a = 32'h0000_0108;
    read_expect(a, 1'b1, 1, "fill before writes");
    exp = mem_word(a);
    write_check(a,     WORD,  32'hdead_beef, exp);
    write_check(a + 1, BYTE,  32'h0000_0011, exp);
    write_check(a + 3, BYTE,  32'h0000_0022, exp);
    write_check(a + 2, HWORD, 32'h0000_3344, exp);
    write_check(a,     HWORD, 32'h0000_5566, exp);
    write_check(a,     BYTE,  32'h0000_0077, exp);
    // Cached copy was merged on every write hit
    access(a, WORD, 1'b0, '0, 1'b1, 1'b0);
    check("merged rdata_o", got_data, exp);
    check("merged read memory accesses", got_ops, 0);
  endtask

  // Three lines of set 0, round-robin evicts the oldest
  task automatic test_replacement();
    read_expect(32'h0000_0200, 1'b1, 1, "set 0 first fill");
    read_expect(32'h0000_0220, 1'b1, 1, "set 0 second fill");
    read_expect(32'h0000_0240, 1'b1, 1, "set 0 eviction");
    read_expect(32'h0000_0220, 1'b1, 0, "second line kept");
    read_expect(32'h0000_0240, 1'b1, 0, "third line kept");
    read_expect(32'h0000_0200, 1'b1, 1, "first line evicted");
  endtask

  task automatic test_uncacheable();
    read_expect(32'h0000_030c, 1'b0, 1, "uncacheable read");
    read_expect(32'h0000_030c, 1'b0, 1, "uncacheable reread");
    read_expect(32'h0000_030c, 1'b1, 1, "cacheable after uncacheable");
    read_expect(32'h0000_030c, 1'b1, 0, "cacheable hit");
  endtask

  task automatic test_misaligned();
    access(32'h0000_0104, WORD, 1'b0, '0, 1'b1, 1'b1);
    check("misaligned read err_o", got_err, 1'b1);
    check("misaligned read memory accesses", got_ops, 0);
    check("misaligned read latency", got_cycles, 1);
    access(32'h0000_0104, WORD, 1'b1, 32'hffff_ffff, 1'b1, 1'b1);
    check("misaligned write err_o", got_err, 1'b1);
    check("misaligned write memory accesses", got_ops, 0);
    check("misaligned write stall_o", got_stall, 1'b0);
    // Line and data untouched
    read_expect(32'h0000_0104, 1'b1, 0, "after misaligned");
  endtask

  task automatic test_flush();
    @(negedge clk_i);
    check("stall_o before flush", stall_o, 1'b0);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    read_expect(32'h0000_0104, 1'b1, 1, "flushed line 104");
    read_expect(32'h0000_0108, 1'b1, 1, "flushed line 108");
    read_expect(32'h0000_0200, 1'b1, 1, "flushed line 200");
    read_expect(32'h0000_0240, 1'b1, 1, "flushed line 240");
    read_expect(32'h0000_030c, 1'b1, 1, "flushed line 30c");
    read_expect(32'h0000_0104, 1'b1, 0, "refilled line 104");
  endtask

  initial
  begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    check("stall_o in reset", stall_o, 1'b0);
    check("ack_o in reset", ack_o, 1'b0);
    check("err_o in reset", err_o, 1'b0);
    check("mem_valid_o in reset", mem_valid_o, 1'b0);
    rst_ni = 1'b1;
    test_miss_then_hit();
    test_write_merge();
    test_replacement();
    test_uncacheable();
    test_misaligned();
    test_flush();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
rtl/cache_pkg.sv
rtl/cache_setup.sv
rtl/cache_ways.sv
rtl/cache_compare.sv
rtl/cache_top.sv
sim/tb_cache.sv
